//--- design/bubbleDrive_cfg.svh
`ifndef BUBBLEDRIVE_CFG_SVH
`define BUBBLEDRIVE_CFG_SVH

// Buffer geometry
`define BUF_ADDR_W 11

// Bit-time counter width
`define CNT_W 14

// Bubble position width and loop length
`define POS_W 12
`define NUM_POSITIONS 2053

// Page sequence: first data point, last data offset
`define PAGE_START 201
`define PAGE_DATA_LAST 1021

// Bootloader sequence: data start, last data offset, last fill offset
`define BOOT_START 5285
`define BOOT_DATA_LAST 2541
`define BOOT_FILL_LAST 3849

`endif

//--- design/bubblePkg.sv
`default_nettype none

package bubblePkg;

    `include "bubbleDrive_cfg.svh"

    // Encodings follow {pageSelect, bubbleAccess, positionLatch}
    typedef enum logic [2:0] {
        initialStandby   = 3'b000,
        bootloaderAccess = 3'b010,
        normalStandby    = 3'b100,
        pageAccess       = 3'b110,
        pageLatch        = 3'b111
    } accessStateT;

    typedef enum logic [1:0] {
        fetchIdle = 2'd0,  // Park read address at all ones
        addrInc   = 2'd1,
        fetch     = 2'd2,
        hold      = 2'd3
    } fetchCmdT;

    typedef enum logic [2:0] {
        outIdle   = 3'd0,  // Lines idle high
        dataOut   = 3'd1,
        pattern01 = 3'd2,
        pattern11 = 3'd3,
        outHold   = 3'd4
    } outCmdT;

    typedef struct packed {
        fetchCmdT fetchCmd;
        outCmdT   outCmd;
    } seqCmdT;

    typedef struct packed {
        logic [`BUF_ADDR_W-1:0] address;
        logic [1:0]             data;
        logic                   writeEnableN;  // Active low
    } bufWriteT;

    typedef struct packed {
        logic odd;
        logic even;
    } bubblePairT;

endpackage

`default_nettype wire

//--- design/accessController.sv
`timescale 1ns/100ps
`default_nettype none

module accessController
    import bubblePkg::*;
(
    input  wire logic bubble_data_output_clock,
    input  wire logic bubbleDataOutputClockCounterEnable,
    input  wire logic pageSelect,
    input  wire logic bubbleAccess,
    input  wire logic positionLatch,
    output logic      loadBootloader,
    output logic      loadPage
);

    accessStateT accessState;
    logic [1:0]  loadLevels;  // {bootloader, page}, active low

    assign loadBootloader = loadLevels[1];
    assign loadPage       = loadLevels[0];

    always_ff @(posedge bubble_data_output_clock or posedge bubbleDataOutputClockCounterEnable)
    begin
        if (bubbleDataOutputClockCounterEnable)
        begin
            accessState <= initialStandby;
            loadLevels  <= 2'b11;
        end
        else
        begin
            unique case ({pageSelect, bubbleAccess, positionLatch})
                3'b000, 3'b100:
                begin
                    if (accessState != pageLatch)  // Dropout during latch is a glitch
                    begin
                        accessState <= pageSelect ? normalStandby : initialStandby;
                        loadLevels  <= 2'b11;
                    end
                end
                3'b010:
                begin
                    if (accessState != pageAccess && accessState != pageLatch)
                    begin
                        accessState <= bootloaderAccess;
                        loadLevels  <= 2'b01;  // Bootloader load-out
                    end
                end
                3'b110:
                begin
                    if (accessState != bootloaderAccess)
                    begin
                        accessState <= pageAccess;  // Levels kept
                    end
                end
                3'b111:
                begin
                    if (accessState == pageAccess || accessState == pageLatch)
                    begin
                        accessState <= pageLatch;
                        loadLevels  <= 2'b10;  // Page load-out
                    end
                end
                default:
                begin
                    accessState <= accessState;  // Latch with partial inputs, hold
                end
            endcase
        end
    end

    // Only one load-out may be active at a time
    assert property (@(posedge bubble_data_output_clock)
        disable iff (bubbleDataOutputClockCounterEnable)
        !(!loadBootloader && !loadPage));

    assert property (@(posedge bubble_data_output_clock)
        disable iff (bubbleDataOutputClockCounterEnable)
        (accessState == pageLatch && $past(accessState) != pageLatch)
            |-> $past(accessState) == pageAccess);

endmodule

`default_nettype wire

//--- design/bitSequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "bubbleDrive_cfg.svh"

module bitSequencer
    import bubblePkg::*;
(
    input  wire logic bubble_data_output_clock,
    input  wire logic bubbleDataOutputClockCounterEnable,
    input  wire logic loadBootloader,
    input  wire logic loadPage,
    output seqCmdT    seqCmd,
    output logic      positionClear
);

    localparam logic [`CNT_W-1:0] pageInc    = `PAGE_START - 4;
    localparam logic [`CNT_W-1:0] pageFetch  = `PAGE_START - 3;
    localparam logic [`CNT_W-1:0] pageDataLo = `PAGE_START - 2;
    localparam logic [`CNT_W-1:0] pageDataHi = `PAGE_START + `PAGE_DATA_LAST;

    localparam logic [`CNT_W-1:0] bootPat01a = `BOOT_START - 6;
    localparam logic [`CNT_W-1:0] bootPat01b = `BOOT_START - 5;
    localparam logic [`CNT_W-1:0] bootInc    = `BOOT_START - 4;
    localparam logic [`CNT_W-1:0] bootFetch  = `BOOT_START - 3;
    localparam logic [`CNT_W-1:0] bootDataLo = `BOOT_START - 2;
    localparam logic [`CNT_W-1:0] bootDataHi = `BOOT_START + `BOOT_DATA_LAST;
    localparam logic [`CNT_W-1:0] bootFillHi = `BOOT_START + `BOOT_FILL_LAST;

    logic [`CNT_W-1:0] bitCounter;
    seqCmdT            nextCmd;

    // Free-running while a load-out level is low, parked at all ones otherwise
    always_ff @(posedge bubble_data_output_clock or posedge bubbleDataOutputClockCounterEnable)
    begin
        if (bubbleDataOutputClockCounterEnable)
            bitCounter <= '1;
        else if (loadBootloader && loadPage)
            bitCounter <= '1;
        else
            bitCounter <= bitCounter + 1'b1;  // Wraps to 0 on first active cycle
    end

    always_comb
    begin
        nextCmd.fetchCmd = fetchIdle;
        nextCmd.outCmd   = outIdle;
        unique case ({loadBootloader, loadPage})
            2'b01:
            begin
                if (bitCounter == bootPat01a || bitCounter == bootPat01b)
                    nextCmd.outCmd = pattern01;  // Start pattern
                else if (bitCounter == bootInc)
                begin
                    nextCmd.fetchCmd = addrInc;
                    nextCmd.outCmd   = pattern11;
                end
                else if (bitCounter == bootFetch)
                begin
                    nextCmd.fetchCmd = fetch;
                    nextCmd.outCmd   = pattern11;
                end
                else if (bitCounter >= bootDataLo && bitCounter <= bootDataHi)
                begin
                    nextCmd.fetchCmd = bitCounter[0] ? addrInc : fetch;
                    nextCmd.outCmd   = bitCounter[0] ? dataOut : outHold;
                end
                else if (bitCounter > bootDataHi && bitCounter <= bootFillHi)
                    nextCmd.outCmd = pattern11;  // Fill tail
            end
            2'b10:
            begin
                if (bitCounter == pageInc)
                    nextCmd.fetchCmd = addrInc;
                else if (bitCounter == pageFetch)
                    nextCmd.fetchCmd = fetch;
                else if (bitCounter >= pageDataLo && bitCounter <= pageDataHi)
                begin
                    nextCmd.fetchCmd = bitCounter[0] ? addrInc : fetch;
                    nextCmd.outCmd   = bitCounter[0] ? dataOut : outHold;
                end
            end
            default:
            begin
                nextCmd.outCmd = outIdle;  // Standby or illegal both-low
            end
        endcase
    end

    always_ff @(posedge bubble_data_output_clock or posedge bubbleDataOutputClockCounterEnable)
    begin
        if (bubbleDataOutputClockCounterEnable)
        begin
            seqCmd.fetchCmd <= fetchIdle;
            seqCmd.outCmd   <= outIdle;
        end
        else
            seqCmd <= nextCmd;
    end

    // Position loop restarts just before bootloader data
    assign positionClear = (bitCounter == bootFetch) || (bitCounter == bootDataLo);

    assert property (@(posedge bubble_data_output_clock)
        disable iff (bubbleDataOutputClockCounterEnable)
        seqCmd.outCmd == dataOut |-> $past(!(loadBootloader && loadPage)));

endmodule

`default_nettype wire

//--- design/pageBuffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "bubbleDrive_cfg.svh"

module pageBuffer
    import bubblePkg::*;
(
    input  wire logic     bubble_data_output_clock,
    input  wire logic     bubbleDataOutputClockCounterEnable,
    input  wire bufWriteT bufWrite,
    input  wire fetchCmdT fetchCmd,
    output logic [1:0]    fetchedWord
);

    logic [1:0]             bufferRam [0:(1 << `BUF_ADDR_W)-1];
    logic [`BUF_ADDR_W-1:0] readAddr;

    // Loader port and fetch share one RAM
    always_ff @(posedge bubble_data_output_clock)
    begin
        if (!bufWrite.writeEnableN)
            bufferRam[bufWrite.address] <= bufWrite.data;
        if (fetchCmd == fetch)
            fetchedWord <= bufferRam[readAddr];
    end

    always_ff @(posedge bubble_data_output_clock or posedge bubbleDataOutputClockCounterEnable)
    begin
        if (bubbleDataOutputClockCounterEnable)
            readAddr <= '1;
        else
        begin
            unique case (fetchCmd)
                fetchIdle:
                begin
                    readAddr <= '1;  // Next increment lands on word 0
                end
                addrInc:
                begin
                    readAddr <= readAddr + 1'b1;
                end
                default:
                begin
                    readAddr <= readAddr;  // Fetch and hold
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/outputDriver.sv
`timescale 1ns/100ps
`default_nettype none

module outputDriver
    import bubblePkg::*;
(
    input  wire logic       bubble_data_output_clock,
    input  wire logic       bubbleDataOutputClockCounterEnable,
    input  wire outCmdT     outCmd,
    input  wire logic [1:0] fetchedWord,
    output bubblePairT      bubbleOut
);

    always_ff @(posedge bubble_data_output_clock or posedge bubbleDataOutputClockCounterEnable)
    begin
        if (bubbleDataOutputClockCounterEnable)
        begin
            bubbleOut.odd  <= 1'b1;
            bubbleOut.even <= 1'b1;
        end
        else
        begin
            unique case (outCmd)
                outIdle:
                begin
                    bubbleOut.odd  <= 1'b1;
                    bubbleOut.even <= 1'b1;
                end
                dataOut:
                begin
                    bubbleOut.odd  <= ~fetchedWord[1];  // Lines are active low
                    bubbleOut.even <= ~fetchedWord[0];
                end
                pattern01:
                begin
                    bubbleOut.odd  <= 1'b1;
                    bubbleOut.even <= 1'b0;
                end
                pattern11:
                begin
                    bubbleOut.odd  <= 1'b0;
                    bubbleOut.even <= 1'b0;
                end
                default:
                begin
                    bubbleOut <= bubbleOut;  // Second half of a data bit
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/positionCounter.sv
`timescale 1ns/100ps
`default_nettype none

`include "bubbleDrive_cfg.svh"

module positionCounter
(
    input  wire logic         bubble_data_output_clock,
    input  wire logic         bubbleDataOutputClockCounterEnable,
    input  wire logic         positionChange,
    input  wire logic         positionClear,
    output logic [`POS_W-1:0] bubblePosition
);

    localparam logic [`POS_W-1:0] lastPosition = `NUM_POSITIONS - 1;

    always_ff @(posedge bubble_data_output_clock or posedge bubbleDataOutputClockCounterEnable)
    begin
        if (bubbleDataOutputClockCounterEnable)
            bubblePosition <= '0;
        else if (positionClear)
            bubblePosition <= '0;  // Clear beats a coincident strobe
        else if (positionChange)
        begin
            if (bubblePosition == lastPosition)
                bubblePosition <= '0;
            else
                bubblePosition <= bubblePosition + 1'b1;
        end
    end

    assert property (@(posedge bubble_data_output_clock)
        disable iff (bubbleDataOutputClockCounterEnable)
        bubblePosition <= lastPosition);

endmodule

`default_nettype wire

//--- design/bubbleInterface.sv
`timescale 1ns/100ps
`default_nettype none

`include "bubbleDrive_cfg.svh"

module bubbleInterface
    import bubblePkg::*;
(
    input  wire logic         bubble_data_output_clock,
    input  wire logic         bubbleDataOutputClockCounterEnable,
    input  wire logic         pageSelect,
    input  wire logic         bubbleAccess,
    input  wire logic         positionLatch,
    input  wire logic         positionChange,
    input  wire bufWriteT     bufWrite,
    output logic              loadBootloader,
    output logic              loadPage,
    output bubblePairT        bubbleOut,
    output logic [`POS_W-1:0] bubblePosition
);

    seqCmdT     seqCmd;
    logic       positionClear;
    logic [1:0] fetchedWord;

    accessController accessController0 (
        .bubble_data_output_clock           (bubble_data_output_clock),
        .bubbleDataOutputClockCounterEnable (bubbleDataOutputClockCounterEnable),
        .pageSelect                         (pageSelect),
        .bubbleAccess                       (bubbleAccess),
        .positionLatch                      (positionLatch),
        .loadBootloader                     (loadBootloader),
        .loadPage                           (loadPage)
    );

    bitSequencer bitSequencer0 (
        .bubble_data_output_clock           (bubble_data_output_clock),
        .bubbleDataOutputClockCounterEnable (bubbleDataOutputClockCounterEnable),
        .loadBootloader                     (loadBootloader),
        .loadPage                           (loadPage),
        .seqCmd                             (seqCmd),
        .positionClear                      (positionClear)
    );

    pageBuffer pageBuffer0 (
        .bubble_data_output_clock           (bubble_data_output_clock),
        .bubbleDataOutputClockCounterEnable (bubbleDataOutputClockCounterEnable),
        .bufWrite                           (bufWrite),
        .fetchCmd                           (seqCmd.fetchCmd),
        .fetchedWord                        (fetchedWord)
    );

    outputDriver outputDriver0 (
        .bubble_data_output_clock           (bubble_data_output_clock),
        .bubbleDataOutputClockCounterEnable (bubbleDataOutputClockCounterEnable),
        .outCmd                             (seqCmd.outCmd),
        .fetchedWord                        (fetchedWord),
        .bubbleOut                          (bubbleOut)
    );

    positionCounter positionCounter0 (
        .bubble_data_output_clock           (bubble_data_output_clock),
        .bubbleDataOutputClockCounterEnable (bubbleDataOutputClockCounterEnable),
        .positionChange                     (positionChange),
        .positionClear                      (positionClear),
        .bubblePosition                     (bubblePosition)
    );

endmodule

`default_nettype wire

//--- verif/tbBubbleInterface.sv
`timescale 1ns/100ps
`default_nettype none

`include "bubbleDrive_cfg.svh"

module tbBubbleInterface
    import bubblePkg::*;
();

    localparam int clockPeriod = 8;
    localparam int bufWords    = 1 << `BUF_ADDR_W;
    localparam int maxRecords  = 16;

    logic              bubble_data_output_clock;
    logic              bubbleDataOutputClockCounterEnable;
    logic              pageSelect;
    logic              bubbleAccess;
    logic              positionLatch;
    logic              positionChange;
    bufWriteT          bufWrite;
    logic              loadBootloader;
    logic              loadPage;
    bubblePairT        bubbleOut;
    logic [`POS_W-1:0] bubblePosition;

    logic [1:0]  modelRam [0:bufWords-1];  // Copy of what the loader wrote
    logic        recBoot [0:maxRecords-1];
    logic [31:0] recSeed [0:maxRecords-1];
    int          recStrobes [0:maxRecords-1];
    int          recordCount   = 0;
    int          runCycles     = 0;  // Watchdog budget in clock cycles
    int          modelPosition = 0;

    bubbleInterface dut0 (.*);

    initial
    begin
        bubble_data_output_clock = 1'b0;
        forever #(clockPeriod / 2) bubble_data_output_clock = ~bubble_data_output_clock;
    end

    initial
    begin
        wait (runCycles > 0);
        #(runCycles * clockPeriod);
        $display("ERROR: the run did not finish within %0d clock cycles", runCycles);
        $display("test failed");
        $fatal(1, "Watchdog timeout");
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic afterEdge();
        @(posedge bubble_data_output_clock);
        #1;
    endtask

    // Lines are {pageSelect, bubbleAccess, positionLatch}
    task automatic setAccess(input logic [2:0] lines);
        afterEdge();
        {pageSelect, bubbleAccess, positionLatch} = lines;
    endtask

    task automatic checkPins(input logic [1:0] levels, input logic [1:0] pair, input int count);
        assert ({loadBootloader, loadPage} == levels)
            else stopOnError($sformatf("CHECK FAILED at %0t: load levels %b, expected %b, count %0d",
                $time, {loadBootloader, loadPage}, levels, count));
        assert (bubbleOut == pair)
            else stopOnError($sformatf("CHECK FAILED at %0t: bubble pair %b, expected %b, count %0d",
                $time, bubbleOut, pair, count));
    endtask

    task automatic checkPosition(input string where);
        assert (int'(bubblePosition) == modelPosition)
            else stopOnError($sformatf("CHECK FAILED at %0t: position %0d, expected %0d, %s",
                $time, bubblePosition, modelPosition, where));
    endtask

    task automatic checkStandby(input int cycles);
        repeat (cycles)
        begin
            @(negedge bubble_data_output_clock);
            checkPins(2'b11, 2'b11, 0);  // Count 0 marks standby
        end
    endtask

    // Count n is the pin state presented to the n-th rising edge after the level fell.
    // A decode at counter value v reaches the pins at count v+4.
    function automatic logic [1:0] expectedPair(input logic isBoot, input int n);
        int start;
        int dataEnd;
        start   = isBoot ? `BOOT_START : `PAGE_START;
        dataEnd = start + (isBoot ? `BOOT_DATA_LAST : `PAGE_DATA_LAST) + 4;
        if (n >= start + 2 && n <= dataEnd)
            return ~modelRam[(n - start - 2) / 2];  // Word k at start+2k+2 and +3
        if (isBoot && (n == start - 2 || n == start - 1))
            return 2'b10;  // Start pattern, odd 1 and even 0
        if (isBoot && n >= start && n <= start + `BOOT_FILL_LAST + 4)
            return 2'b00;  // Pattern 11 and fill tail
        return 2'b11;
    endfunction

    task automatic readPatterns();
        int          fd;
        int          fields;
        int          strobes;
        int          total;
        string       line;
        logic [63:0] mode;
        logic [31:0] offset;
        total = 0;
        fd = $fopen("verif/bubblePatterns.txt", "r");
        if (fd == 0)
            stopOnError("ERROR: could not open verif/bubblePatterns.txt");
        while ($fgets(line, fd) > 0)
        begin
            fields = $sscanf(line, "%s %h %d", mode, offset, strobes);
            if (line.getc(0) != "#" && fields == 3)
            begin
                if ((mode != "page" && mode != "boot") || recordCount >= maxRecords)
                    stopOnError($sformatf("ERROR: bad or extra test record: %s", line));
                recBoot[recordCount]    = (mode == "boot");
                recSeed[recordCount]    = offset;
                recStrobes[recordCount] = strobes;
                recordCount++;
                total += bufWords + strobes + 100;
                total += (mode == "boot") ? `BOOT_START + `BOOT_FILL_LAST + 20
                                          : `PAGE_START + `PAGE_DATA_LAST + 20;
            end
        end
        $fclose(fd);
        if (recordCount == 0)
            stopOnError("ERROR: the pattern file holds no test records");
        runCycles = total + total / 5 + 1000;  // Margin covers reset
    endtask

    task automatic fillBuffer(input logic [31:0] seed);
        logic [31:0] state;
        int          a;
        state = seed;
        for (a = 0; a < bufWords; a++)
        begin
            state = nextRandom(state);
            afterEdge();
            bufWrite = '{address: a[`BUF_ADDR_W-1:0], data: state[31:30], writeEnableN: 1'b0};
            modelRam[a] = state[31:30];
        end
        afterEdge();
        bufWrite.writeEnableN = 1'b1;
    endtask

    task automatic sendStrobes(input int count);
        repeat (count)
        begin
            afterEdge();
            positionChange = 1'b1;  // One strobe per cycle
        end
        afterEdge();
        positionChange = 1'b0;
        modelPosition = (modelPosition + count) % `NUM_POSITIONS;
        @(negedge bubble_data_output_clock);
        checkPosition("after the position strobes");
    endtask

    task automatic runAccess(input logic isBoot);
        logic [1:0] active;
        int         lastCount;
        int         tries;
        int         n;
        active    = isBoot ? 2'b01 : 2'b10;
        lastCount = isBoot ? `BOOT_START + `BOOT_FILL_LAST + 20
                           : `PAGE_START + `PAGE_DATA_LAST + 20;
        if (isBoot)
            setAccess(3'b010);
        else
        begin
            setAccess(3'b100);
            setAccess(3'b110);
            setAccess(3'b111);
        end
        tries = 0;
        while ({loadBootloader, loadPage} == 2'b11)
        begin
            assert (tries < 8)
                else stopOnError("ERROR: no load level fell after the access sequence");
            @(negedge bubble_data_output_clock);
            tries++;
        end
        for (n = 1; n <= lastCount; n++)
        begin
            if (n > 1)
                @(negedge bubble_data_output_clock);
            checkPins(active, expectedPair(isBoot, n), n);
            if (isBoot && n == `BOOT_START)
                modelPosition = 0;  // Clear window has passed
            if (n == 1 || n == lastCount || (isBoot && n == `BOOT_START + 4))
                checkPosition($sformatf("count %0d", n));
            if (n == 4)
                setAccess(isBoot ? 3'b110 : 3'b000);  // Glitch that must be ignored
            else if (n == 5)
                setAccess(3'b111);  // Latch is refused unless page access was taken
            else if (n == 8)
                setAccess(isBoot ? 3'b010 : 3'b110);  // Page latch released, level stays low
        end
        if (!isBoot)
            setAccess(3'b100);
        setAccess(3'b000);
        repeat (2) @(negedge bubble_data_output_clock);
        checkStandby(8);
    endtask

    initial
    begin
        int r;
        bubbleDataOutputClockCounterEnable = 1'b1;
        pageSelect     = 1'b0;
        bubbleAccess   = 1'b0;
        positionLatch  = 1'b0;
        positionChange = 1'b0;
        bufWrite       = '{address: '0, data: 2'b00, writeEnableN: 1'b1};
        readPatterns();
        repeat (10) @(posedge bubble_data_output_clock);
        #1;
        bubbleDataOutputClockCounterEnable = 1'b0;
        checkStandby(4);
        checkPosition("after reset");
        for (r = 0; r < recordCount; r++)
        begin
            fillBuffer(32'h9e874824 + recSeed[r]);
            sendStrobes(recStrobes[r]);
            runAccess(recBoot[r]);
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+design
design/bubblePkg.sv
design/accessController.sv
design/bitSequencer.sv
design/pageBuffer.sv
design/outputDriver.sv
design/positionCounter.sv
design/bubbleInterface.sv
verif/tbBubbleInterface.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; a failing run exits nonzero
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module tbBubbleInterface \
    -f project.f \
    -o tbBubbleInterface
./obj_dir/tbBubbleInterface

//--- verif/bubblePatterns.txt
# mode (page or boot)   LCG seed offset (hex)   positionChange strobes (decimal)
# Each record refills the buffer from the LCG, sends the strobes, then runs one access
page 00000000 5
boot 00000001 300
page 0000a5a5 2053
page 00000010 0
boot 7f3c0001 2060
page 12345678 4107
boot 00000002 1
page ffffffff 17
